// File: blank_gen.sv
`timescale 1ns/1ns

module blank_gen #(
	parameter int coord_w = video_crop_pkg::coord_w
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     hs,
	raster_if.sink   rast,
	crop_if.user     crop,
	output logic     hde,
	output logic     vde
);

	localparam logic [coord_w-1:0] lead   = coord_w'(video_crop_pkg::soft_lead);
	localparam logic [coord_w-1:0] margin = coord_w'(video_crop_pkg::force_margin);

	logic               shbl, fhbl, svbl, fvbl;
	logic               hbl;
	logic               vstep;
	logic [coord_w-1:0] h_open, h_close, h_force_end;
	logic [coord_w-1:0] v_open, v_close, v_force_sta, v_force_end;

	assign h_open      = rast.hend + crop.hbl_l - lead;
	assign h_close     = rast.hsta + crop.hbl_r - lead;
	assign h_force_end = rast.hmax - margin;

	// Negative bottom offset counts back from the last line
	assign v_open      = rast.vend + crop.vbl_t;
	assign v_close     = crop.vbl_b[coord_w-1] ? rast.vmax + crop.vbl_b : crop.vbl_b;
	assign v_force_sta = rast.vmax - 1'd1;
	assign v_force_end = rast.vs_end + 2'd2;

	assign hbl   = fhbl | shbl | ~hs;
	assign vstep = rast.hbl_line | (rast.vcnt == '0);
	assign vde   = ~(fvbl | svbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
			svbl <= 1'b1;
			fvbl <= 1'b1;
			hde  <= 1'b0;
		end else begin
			if (rast.hcnt == h_open)  shbl <= 1'b0;
			if (rast.hcnt == h_close) shbl <= 1'b1;

			if (rast.hcnt == margin)      fhbl <= 1'b0;   // Clip both line ends
			if (rast.hcnt == h_force_end) fhbl <= 1'b1;

			if (vstep) begin
				if (rast.vcnt == v_open)      svbl <= 1'b0;
				if (rast.vcnt == v_close)     svbl <= 1'b1;
				if (rast.vcnt == v_force_sta) fvbl <= 1'b1;
				if (rast.vcnt == v_force_end) fvbl <= 1'b0;
			end

			hde <= ~hbl;
		end
	end

endmodule

// File: crop_adjust.sv
`timescale 1ns/1ns

module crop_adjust #(
	parameter int coord_w = video_crop_pkg::coord_w
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] kbd_data,
	input  logic [1:0] kbd_type,
	input  logic       kbd_level,
	crop_if.owner      crop
);

	localparam logic [coord_w-1:0] h_step = coord_w'(video_crop_pkg::h_step);
	localparam logic [coord_w-1:0] v_step = coord_w'(video_crop_pkg::v_step);

	logic       level_q;
	logic       level_qq;
	logic [7:0] data_q;
	logic [1:0] type_q;
	logic       alt;
	logic       key_evt;

	// Toggle on the level line marks a new event
	assign key_evt = (level_q ^ level_qq) && (type_q == video_crop_pkg::kbd_type_key);

	always_ff @(posedge clk_sys) begin
		data_q <= kbd_data;
		type_q <= kbd_type;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_q    <= 1'b0;
			level_qq   <= 1'b0;
			alt        <= 1'b0;
			crop.hbl_l <= '0;
			crop.hbl_r <= '0;
			crop.vbl_t <= '0;
			crop.vbl_b <= '0;
		end else begin
			level_q  <= kbd_level;
			level_qq <= level_q;

			if (key_evt) begin
				case (data_q)
					video_crop_pkg::key_reset_crop: begin
						crop.hbl_l <= '0;
						crop.hbl_r <= '0;
						crop.vbl_t <= '0;
						crop.vbl_b <= '0;
					end
					video_crop_pkg::key_up: begin
						if (alt) crop.vbl_b <= crop.vbl_b + v_step;
						else     crop.vbl_t <= crop.vbl_t + v_step;
					end
					video_crop_pkg::key_down: begin
						if (alt) crop.vbl_b <= crop.vbl_b - v_step;
						else     crop.vbl_t <= crop.vbl_t - v_step;
					end
					video_crop_pkg::key_left: begin
						if (alt) crop.hbl_r <= crop.hbl_r + h_step;
						else     crop.hbl_l <= crop.hbl_l + h_step;
					end
					video_crop_pkg::key_right: begin
						if (alt) crop.hbl_r <= crop.hbl_r - h_step;
						else     crop.hbl_l <= crop.hbl_l - h_step;
					end
					video_crop_pkg::key_alt_press_a,
					video_crop_pkg::key_alt_press_b:   alt <= 1'b1;
					video_crop_pkg::key_alt_release_a,
					video_crop_pkg::key_alt_release_b: alt <= 1'b0;
					default: ;
				endcase
			end

			// Host load wins over a key in the same cycle
			if (crop.set_h) begin
				crop.hbl_l <= crop.set_data[coord_w-1:0];
				crop.hbl_r <= crop.set_data[2*coord_w-1:coord_w];
			end
			if (crop.set_v) begin
				crop.vbl_t <= crop.set_data[coord_w-1:0];
				crop.vbl_b <= crop.set_data[2*coord_w-1:coord_w];
			end
		end
	end

endmodule

// File: crop_if.sv
`timescale 1ns/1ns

interface crop_if #(
	parameter int coord_w = 12
);

	logic [coord_w-1:0]   hbl_l;    // Left crop
	logic [coord_w-1:0]   hbl_r;    // Right crop
	logic [coord_w-1:0]   vbl_t;    // Top crop
	logic [coord_w-1:0]   vbl_b;    // Bottom crop
	logic                 set_h;    // Host load of left/right
	logic                 set_v;    // Host load of top/bottom
	logic [2*coord_w-1:0] set_data; // High offset above low offset

	modport owner (output hbl_l, hbl_r, vbl_t, vbl_b, input set_h, set_v, set_data);

	modport setter (output set_h, set_v, set_data, input hbl_l, hbl_r, vbl_t, vbl_b);

	modport user (input hbl_l, hbl_r, vbl_t, vbl_b);

endinterface

// File: raster_if.sv
`timescale 1ns/1ns

interface raster_if #(
	parameter int coord_w = 12
);

	logic [coord_w-1:0] hcnt;     // Position in line
	logic [coord_w-1:0] vcnt;     // Line in frame
	logic [coord_w-1:0] hsta;     // Start of horizontal blank
	logic [coord_w-1:0] hend;     // End of horizontal blank
	logic [coord_w-1:0] hmax;     // Last count before sync
	logic [coord_w-1:0] vend;     // End of vertical blank
	logic [coord_w-1:0] vmax;     // Start of vertical blank
	logic [coord_w-1:0] vs_end;   // Line where vsync ends
	logic               hbl_line; // Horizontal blank falling edge

	modport source (
		output hcnt, vcnt, hsta, hend, hmax, vend, vmax, vs_end, hbl_line
	);

	modport sink (
		input hcnt, vcnt, hsta, hend, hmax, vend, vmax, vs_end, hbl_line
	);

endinterface

// File: raster_measure.sv
`timescale 1ns/1ns

module raster_measure #(
	parameter int coord_w = video_crop_pkg::coord_w
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,
	input  logic               vs,
	input  logic               hblank,
	input  logic               vblank,
	raster_if.source           rast,
	output logic [coord_w-1:0] hsize,
	output logic [coord_w-1:0] vsize
);

	logic old_hs;
	logic old_vs;
	logic old_hblank;
	logic old_vbl;
	logic old_hbl;
	logic vbl;
	logic hbl;

	// Sync periods count as blanking
	assign vbl = vblank | ~vs;
	assign hbl = hblank | ~hs;

	assign rast.hbl_line = old_hbl & ~hbl;   // Start of active part of line

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b0;
			old_vs     <= 1'b0;
			old_hblank <= 1'b0;
			old_vbl    <= 1'b0;
			old_hbl    <= 1'b0;
		end else begin
			old_hs     <= hs;
			old_vs     <= vs;
			old_hblank <= hblank;
			old_vbl    <= vbl;
			old_hbl    <= hbl;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rast.hcnt <= '0;
			rast.hend <= '0;
			rast.hsta <= '0;
			rast.hmax <= '0;
			hsize     <= '0;
		end else begin
			if (hs) rast.hcnt <= rast.hcnt + 1'd1;
			else    rast.hcnt <= '0;            // Held at zero during sync

			if (old_hblank & ~hblank) rast.hend <= rast.hcnt;
			if (~old_hblank & hblank) rast.hsta <= rast.hcnt;
			if (old_hs & ~hs)         rast.hmax <= rast.hcnt;

			// Line width taken from line 1 only
			if (~old_hblank & hblank & (rast.vcnt == coord_w'(1)))
				hsize <= rast.hcnt - rast.hend;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rast.vcnt   <= '0;
			rast.vend   <= '0;
			rast.vmax   <= '0;
			rast.vs_end <= '0;
			vsize       <= '0;
		end else begin
			if (old_hs & ~hs) rast.vcnt <= rast.vcnt + 1'd1;

			if (old_vbl & ~vbl) rast.vend   <= rast.vcnt;
			if (~old_vs & vs)   rast.vs_end <= rast.vcnt;

			if (~old_vbl & vbl) begin
				rast.vcnt <= '0;                 // Frame restarts at blank
				rast.vmax <= rast.vcnt;
				vsize     <= rast.vcnt - rast.vend;
			end
		end
	end

endmodule

// File: screen_info_apb.sv
`timescale 1ns/1ns

module screen_info_apb #(
	parameter int coord_w = video_crop_pkg::coord_w
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      vs,
	input  logic                      vblank,
	input  video_crop_pkg::res_t      res,
	input  logic [coord_w-1:0]        hsize,
	input  logic [coord_w-1:0]        vsize,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  video_crop_pkg::apb_addr_t paddr,
	input  video_crop_pkg::reg_word_t pwdata,
	output video_crop_pkg::reg_word_t prdata,
	crop_if.setter                    crop
);

	logic                 vbl;
	logic                 old_vbl;
	logic                 vbl_end;
	logic                 access;
	logic [coord_w-1:0]   scr_hbl_l, scr_hbl_r;
	logic [coord_w-1:0]   scr_vbl_t, scr_vbl_b;
	logic [coord_w-1:0]   scr_hsize, scr_vsize;
	video_crop_pkg::res_t  scr_res;
	video_crop_pkg::flag_t scr_flg;

	assign vbl    = vblank | ~vs;
	assign access = psel & penable;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vbl   <= 1'b0;
			vbl_end   <= 1'b0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= '0;
			scr_flg   <= '0;
		end else begin
			old_vbl <= vbl;
			vbl_end <= old_vbl & ~vbl;   // End of vertical blank seen
			if (vbl_end) begin
				scr_hbl_l <= crop.hbl_l;
				scr_hbl_r <= crop.hbl_r;
				scr_vbl_t <= crop.vbl_t;
				scr_vbl_b <= crop.vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				// Count geometry changes for the host
				if (scr_res != res || scr_hsize != hsize || scr_vsize != vsize)
					scr_flg <= scr_flg + 1'd1;
			end
		end
	end

	// Crop writes become one-cycle set pulses
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			crop.set_h <= 1'b0;
			crop.set_v <= 1'b0;
		end else begin
			crop.set_h <= access & pwrite & (paddr == video_crop_pkg::addr_crop_h);
			crop.set_v <= access & pwrite & (paddr == video_crop_pkg::addr_crop_v);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (access & pwrite) crop.set_data <= pwdata[2*coord_w-1:0];
	end

	always_comb begin
		prdata = '0;
		if (access & ~pwrite) begin
			case (paddr)
				video_crop_pkg::addr_crop_h: prdata = video_crop_pkg::reg_word_t'({scr_hbl_r, scr_hbl_l});
				video_crop_pkg::addr_crop_v: prdata = video_crop_pkg::reg_word_t'({scr_vbl_b, scr_vbl_t});
				video_crop_pkg::addr_size:   prdata = video_crop_pkg::reg_word_t'({scr_vsize, scr_hsize});
				video_crop_pkg::addr_status: prdata = video_crop_pkg::reg_word_t'({scr_flg, 6'd0, scr_res});
				default:                     prdata = '0;   // Unmapped
			endcase
		end
	end

endmodule

// File: src.f
video_crop_pkg.sv
raster_if.sv
crop_if.sv
raster_measure.sv
crop_adjust.sv
blank_gen.sv
screen_info_apb.sv
video_crop_top.sv
tb_video_crop_assertions.sv
tb_video_crop.sv

// File: tb_video_crop.sv
`timescale 1ns/1ns

module tb_video_crop;

	localparam int coord_w     = video_crop_pkg::coord_w;
	localparam int line_len    = 200;   // Cycles per line
	localparam int hs_len      = 12;
	localparam int h_act_first = 40;
	localparam int h_act_last  = 179;
	localparam int frame_len   = 30;    // Lines per frame
	localparam int vs_len      = 2;
	localparam int v_act_first = 6;
	localparam int v_act_last  = 25;
	localparam int wait_limit  = 5000;

	localparam logic [coord_w-1:0] h_inc = coord_w'(video_crop_pkg::h_step);
	localparam logic [coord_w-1:0] v_inc = coord_w'(video_crop_pkg::v_step);

	logic                      clk_sys;
	logic                      reset;
	logic                      hs;
	logic                      vs;
	logic                      hblank;
	logic                      vblank;
	video_crop_pkg::res_t      res;
	logic [7:0]                kbd_data;
	logic [1:0]                kbd_type;
	logic                      kbd_level;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	video_crop_pkg::apb_addr_t paddr;
	video_crop_pkg::reg_word_t pwdata;
	video_crop_pkg::reg_word_t prdata;
	logic                      hde;
	logic                      vde;

	int                    hpos;
	int                    vline;
	int                    errors;
	int                    timeouts;
	integer                seed;
	logic [coord_w-1:0]    exp_l, exp_r, exp_t, exp_b;   // Expected live crop offsets
	logic                  exp_alt;
	video_crop_pkg::flag_t flag_base;

	video_crop_top dut0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.hs        (hs),
		.vs        (vs),
		.hblank    (hblank),
		.vblank    (vblank),
		.res       (res),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.hde       (hde),
		.vde       (vde)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	task automatic drive_raster();
		hs     = (hpos >= hs_len);
		hblank = (hpos < h_act_first) || (hpos > h_act_last);
		vs     = (vline >= vs_len);
		vblank = (vline < v_act_first) || (vline > v_act_last);
	endtask

	// Free running raster, starts at line 0 once reset is released
	initial begin
		hpos  = 0;
		vline = 0;
		drive_raster();
		@(negedge reset);
		forever begin
			@(posedge clk_sys);
			#1;
			if (hpos == line_len - 1) begin
				hpos  = 0;
				vline = (vline == frame_len - 1) ? 0 : vline + 1;
			end else begin
				hpos = hpos + 1;
			end
			drive_raster();
		end
	end

	task automatic check_word(input string name, input video_crop_pkg::reg_word_t exp,
			input video_crop_pkg::reg_word_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_coord(input string name, input logic [coord_w-1:0] exp,
			input logic [coord_w-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input video_crop_pkg::flag_t exp,
			input video_crop_pkg::flag_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	task automatic apb_write(input video_crop_pkg::apb_addr_t addr,
			input video_crop_pkg::reg_word_t data);
		@(posedge clk_sys);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		@(posedge clk_sys);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		repeat (2) @(posedge clk_sys);   // Set pulse, then offset load
	endtask

	task automatic apb_read(input video_crop_pkg::apb_addr_t addr,
			output video_crop_pkg::reg_word_t data);
		@(posedge clk_sys);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		@(negedge clk_sys);
		data = prdata;                   // Mid access cycle
		@(posedge clk_sys);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apply_key(input logic [7:0] code);
		case (code)
			video_crop_pkg::key_reset_crop: begin
				exp_l = '0;
				exp_r = '0;
				exp_t = '0;
				exp_b = '0;
			end
			video_crop_pkg::key_up: begin
				if (exp_alt) exp_b = exp_b + v_inc;
				else         exp_t = exp_t + v_inc;
			end
			video_crop_pkg::key_down: begin
				if (exp_alt) exp_b = exp_b - v_inc;
				else         exp_t = exp_t - v_inc;
			end
			video_crop_pkg::key_left: begin
				if (exp_alt) exp_r = exp_r + h_inc;
				else         exp_l = exp_l + h_inc;
			end
			video_crop_pkg::key_right: begin
				if (exp_alt) exp_r = exp_r - h_inc;
				else         exp_l = exp_l - h_inc;
			end
			video_crop_pkg::key_alt_press_a, video_crop_pkg::key_alt_press_b:     exp_alt = 1'b1;
			video_crop_pkg::key_alt_release_a, video_crop_pkg::key_alt_release_b: exp_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic send_key(input logic [7:0] code);
		@(posedge clk_sys);
		#1;
		kbd_data  = code;
		kbd_type  = video_crop_pkg::kbd_type_key;
		kbd_level = ~kbd_level;          // Toggle marks the event
		repeat (3) @(posedge clk_sys);
		apply_key(code);
	endtask

	task automatic wait_vblank(input logic level);
		int n;
		n = 0;
		while (vblank !== level && n < wait_limit) begin
			@(posedge clk_sys);
			n++;
		end
		if (vblank !== level) begin
			timeouts++;
			$display("Timed out waiting for vblank to go %s", level ? "high" : "low");
		end
	endtask

	// Passes one full end of vertical blank and the snapshot load after it
	task automatic wait_frame();
		wait_vblank(1'b0);
		wait_vblank(1'b1);
		wait_vblank(1'b0);
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic count_hde(output int cnt);
		cnt = 0;
		repeat (line_len) begin
			@(negedge clk_sys);
			if (hde) cnt++;
		end
	endtask

	task automatic count_vde(output int cnt);
		cnt = 0;
		repeat (frame_len * line_len) begin
			@(negedge clk_sys);
			if (vde) cnt++;
		end
	endtask

	// Positions in hcnt units, hcnt starts counting when hs rises
	function automatic int hde_expect(input int left, input int right);
		int lo;
		int hi;
		lo = (h_act_first - hs_len) + left - video_crop_pkg::soft_lead;
		hi = (h_act_last + 1 - hs_len) + right - video_crop_pkg::soft_lead;
		if (lo < video_crop_pkg::force_margin)
			lo = video_crop_pkg::force_margin;
		if (hi > (line_len - 1 - hs_len) - video_crop_pkg::force_margin)   // hmax is last count
			hi = (line_len - 1 - hs_len) - video_crop_pkg::force_margin;
		return (hi > lo) ? hi - lo : 0;
	endfunction

	// Lines in vcnt units, vcnt restarts when vertical blank begins
	function automatic int vde_expect(input int top);
		int ofs;
		int lo;
		int hi;
		ofs = frame_len - 1 - v_act_last;     // Blank lines counted before line 0
		lo  = (v_act_first - 1 + ofs) + top;  // vend holds the last blank line
		if (lo < (vs_len - 1 + ofs) + 2)
			lo = (vs_len - 1 + ofs) + 2;
		hi  = (v_act_last + ofs) - 1;         // Forced blank from vmax less one
		return (hi > lo) ? (hi - lo) * line_len : 0;
	endfunction

	task automatic check_size();
		video_crop_pkg::reg_word_t rd;
		apb_read(video_crop_pkg::addr_size, rd);
		check_coord("hsize", coord_w'(h_act_last - h_act_first + 1), rd[coord_w-1:0]);
		check_coord("vsize", coord_w'(v_act_last - v_act_first + 1), rd[2*coord_w-1:coord_w]);
	endtask

	task automatic check_crops();
		video_crop_pkg::reg_word_t rd;
		apb_read(video_crop_pkg::addr_crop_h, rd);
		check_coord("crop_left", exp_l, rd[coord_w-1:0]);
		check_coord("crop_right", exp_r, rd[2*coord_w-1:coord_w]);
		apb_read(video_crop_pkg::addr_crop_v, rd);
		check_coord("crop_top", exp_t, rd[coord_w-1:0]);
		check_coord("crop_bottom", exp_b, rd[2*coord_w-1:coord_w]);
	endtask

	task automatic reset_state_check();
		video_crop_pkg::reg_word_t rd;
		wait_frame();
		wait_frame();
		check_crops();
		check_size();
		apb_read(video_crop_pkg::addr_status, rd);
		check_word("status_res", '0, rd & ~32'h0000_7F00);
		flag_base = 7'd2;                // hsize and vsize settle one frame apart after reset
		check_flag("status_flag", flag_base, rd[14:8]);
		wait_frame();
		apb_read(video_crop_pkg::addr_status, rd);
		check_flag("status_flag", flag_base, rd[14:8]);
		apb_read(4'h2, rd);
		check_word("unmapped", '0, rd);
	endtask

	task automatic host_crop_check();
		logic [31:0] rnd;
		rnd   = $random(seed);
		exp_l = coord_w'(rnd[7:0]);
		exp_r = coord_w'(rnd[15:8]);
		exp_t = coord_w'(rnd[23:16]);
		exp_b = coord_w'(rnd[31:24]);
		apb_write(video_crop_pkg::addr_crop_h, video_crop_pkg::reg_word_t'({exp_r, exp_l}));
		apb_write(video_crop_pkg::addr_crop_v, video_crop_pkg::reg_word_t'({exp_b, exp_t}));
		wait_frame();
		check_crops();
		apb_write(video_crop_pkg::addr_size, 32'h00AB_CDEF);   // Read only
		wait_frame();
		check_size();
		check_crops();
	endtask

	task automatic key_crop_check();
		apb_write(video_crop_pkg::addr_crop_h, '0);
		apb_write(video_crop_pkg::addr_crop_v, '0);
		exp_l = '0;
		exp_r = '0;
		exp_t = '0;
		exp_b = '0;
		send_key(video_crop_pkg::key_left);
		send_key(video_crop_pkg::key_left);
		wait_frame();
		check_crops();
		send_key(video_crop_pkg::key_alt_press_a);
		send_key(video_crop_pkg::key_up);
		wait_frame();
		check_crops();
		send_key(video_crop_pkg::key_alt_release_a);
		send_key(video_crop_pkg::key_down);
		wait_frame();
		check_crops();
		send_key(video_crop_pkg::key_reset_crop);
		wait_frame();
		check_crops();
	endtask

	task automatic hde_width_check();
		int cnt_open;
		int cnt_crop;
		count_hde(cnt_open);
		check_coord("hde_count", coord_w'(hde_expect(int'(exp_l), int'(exp_r))),
			coord_w'(cnt_open));
		send_key(video_crop_pkg::key_left);
		send_key(video_crop_pkg::key_left);
		repeat (line_len) @(posedge clk_sys);   // Whole line with the new crop
		count_hde(cnt_crop);
		check_coord("hde_count_left", coord_w'(hde_expect(int'(exp_l), int'(exp_r))),
			coord_w'(cnt_crop));
		check_coord("hde_reduction", coord_w'(2 * video_crop_pkg::h_step),
			coord_w'(cnt_open - cnt_crop));
	endtask

	task automatic vde_height_check();
		int cnt_open;
		int cnt_top;
		count_vde(cnt_open);
		check_coord("vde_count", coord_w'(vde_expect(int'(exp_t))), coord_w'(cnt_open));
		send_key(video_crop_pkg::key_up);
		repeat (frame_len * line_len) @(posedge clk_sys);   // Whole frame with the new crop
		count_vde(cnt_top);
		check_coord("vde_count_top", coord_w'(vde_expect(int'(exp_t))), coord_w'(cnt_top));
	endtask

	task automatic res_change_check();
		video_crop_pkg::reg_word_t rd;
		@(posedge clk_sys);
		#1;
		res = 2'd2;
		wait_frame();
		wait_frame();
		apb_read(video_crop_pkg::addr_status, rd);
		check_word("status_res", video_crop_pkg::reg_word_t'(res), rd & 32'h0000_0003);
		check_flag("status_flag", video_crop_pkg::flag_t'(flag_base + 7'd1), rd[14:8]);
		wait_frame();
		apb_read(video_crop_pkg::addr_status, rd);
		check_flag("status_flag", video_crop_pkg::flag_t'(flag_base + 7'd1), rd[14:8]);
	endtask

	initial begin
		errors    = 0;
		timeouts  = 0;
		seed      = 32'hcf8e8ba3;
		exp_l     = '0;
		exp_r     = '0;
		exp_t     = '0;
		exp_b     = '0;
		exp_alt   = 1'b0;
		flag_base = '0;
		reset     = 1'b1;
		res       = '0;
		kbd_data  = '0;
		kbd_type  = '0;
		kbd_level = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		reset_state_check();
		host_crop_check();
		key_crop_check();
		hde_width_check();
		vde_height_check();
		res_change_check();

		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, dut0.u_assert.fail_cnt);
		if (errors == 0 && timeouts == 0 && dut0.u_assert.fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb_video_crop_assertions.sv
`timescale 1ns/1ns

module tb_video_crop_assertions #(
	parameter int coord_w = video_crop_pkg::coord_w
) (
	input logic                      clk_sys,
	input logic                      reset,
	input logic                      hs,
	input logic                      psel,
	input logic                      penable,
	input video_crop_pkg::reg_word_t prdata,
	input logic                      hde,
	input logic                      vde,
	input logic [coord_w-1:0]        vcnt
);

	int fail_cnt = 0;   // Read by the testbench at the end

	prdata_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!psel |-> prdata == '0)
		else begin
			fail_cnt++;
			$error("prdata is not zero while psel is low");
		end

	hde_in_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!hs |=> !hde)
		else begin
			fail_cnt++;
			$error("hde is high in the cycle after hs was low");
		end

	// First cycle of line 0 is skipped, the blank terms load one edge later
	vde_first_line: assert property (@(posedge clk_sys) disable iff (reset)
		(vcnt == '0) && ($past(vcnt) == '0) |-> !vde)
		else begin
			fail_cnt++;
			$error("vde is high on the first line of a frame");
		end

	penable_needs_psel: assert property (@(posedge clk_sys) disable iff (reset)
		penable |-> psel)
		else begin
			fail_cnt++;
			$error("penable is high without psel");
		end

endmodule

bind video_crop_top tb_video_crop_assertions #(.coord_w(coord_w)) u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.hs      (hs),
	.psel    (psel),
	.penable (penable),
	.prdata  (prdata),
	.hde     (hde),
	.vde     (vde),
	.vcnt    (rast.vcnt)
);

// File: video_crop_pkg.sv
package video_crop_pkg;

	parameter int coord_w = 12;    // Counter and offset width

	typedef logic [1:0]  res_t;    // Resolution code
	typedef logic [6:0]  flag_t;   // Snapshot change counter
	typedef logic [31:0] reg_word_t;
	typedef logic [3:0]  apb_addr_t;

	// Keycodes from the keyboard event stream
	parameter logic [7:0] key_reset_crop    = 8'h41;   // Backspace
	parameter logic [7:0] key_up            = 8'h4C;
	parameter logic [7:0] key_down          = 8'h4D;
	parameter logic [7:0] key_left          = 8'h4F;
	parameter logic [7:0] key_right         = 8'h4E;
	parameter logic [7:0] key_alt_press_a   = 8'h64;
	parameter logic [7:0] key_alt_press_b   = 8'h65;
	parameter logic [7:0] key_alt_release_a = 8'hE4;
	parameter logic [7:0] key_alt_release_b = 8'hE5;

	parameter logic [1:0] kbd_type_key = 2'd3;   // Event carries a keycode

	parameter int h_step       = 4;   // Horizontal crop step
	parameter int v_step       = 1;   // Vertical crop step
	parameter int force_margin = 8;   // Forced blank at both line ends
	parameter int soft_lead    = 2;   // Soft blank edge lead

	// APB register offsets
	parameter apb_addr_t addr_crop_h = 4'h0;
	parameter apb_addr_t addr_crop_v = 4'h4;
	parameter apb_addr_t addr_size   = 4'h8;
	parameter apb_addr_t addr_status = 4'hC;

endpackage

// File: video_crop_top.sv
`timescale 1ns/1ns

module video_crop_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      hs,       // Active low
	input  logic                      vs,       // Active low
	input  logic                      hblank,
	input  logic                      vblank,
	input  video_crop_pkg::res_t      res,
	input  logic [7:0]                kbd_data,
	input  logic [1:0]                kbd_type,
	input  logic                      kbd_level,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  video_crop_pkg::apb_addr_t paddr,
	input  video_crop_pkg::reg_word_t pwdata,
	output video_crop_pkg::reg_word_t prdata,
	output logic                      hde,
	output logic                      vde
);

	localparam int coord_w = video_crop_pkg::coord_w;

	logic [coord_w-1:0] hsize;
	logic [coord_w-1:0] vsize;

	raster_if #(.coord_w(coord_w)) rast ();
	crop_if   #(.coord_w(coord_w)) crop ();

	raster_measure #(.coord_w(coord_w)) u_measure (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.rast    (rast.source),
		.hsize   (hsize),
		.vsize   (vsize)
	);

	crop_adjust #(.coord_w(coord_w)) u_adjust (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.crop      (crop.owner)
	);

	blank_gen #(.coord_w(coord_w)) u_blank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.rast    (rast.sink),
		.crop    (crop.user),
		.hde     (hde),
		.vde     (vde)
	);

	screen_info_apb #(.coord_w(coord_w)) u_info (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vs      (vs),
		.vblank  (vblank),
		.res     (res),
		.hsize   (hsize),
		.vsize   (vsize),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.crop    (crop.setter)
	);

endmodule
